// File: src/ooo_commit_pkg.sv
package ooo_commit_pkg;

  // Completion buffer size and the widths derived from it
  localparam int CB_DEPTH = 8;
  localparam int CB_IDX_W = $clog2(CB_DEPTH);

  // Entry index into the buffer
  typedef logic [CB_IDX_W-1:0] cb_idx_t;

  // Index plus wrap bit, so full and empty can be told apart
  typedef logic [CB_IDX_W:0] cb_ptr_t;

  // Opcodes seen at dispatch
  typedef enum logic [2:0] {
    OP_NOP     = 3'd0,
    OP_ADD     = 3'd1,
    OP_SUB     = 3'd2,
    OP_XOR     = 3'd3,
    OP_MUL     = 3'd4,
    OP_ILLEGAL = 3'd5
  } opcode_t;

  // Instruction as presented on the dispatch port, 104 bits
  typedef struct packed {
    opcode_t     op;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
  } dispatch_req_t;

  // Issue to one functional unit, tagged with its buffer entry
  typedef struct packed {
    logic        valid;
    opcode_t     op;
    cb_idx_t     idx;
    logic [31:0] a;
    logic [31:0] b;
  } fu_issue_t;

  // Result strobe from a unit back into the buffer
  typedef struct packed {
    logic        valid;
    cb_idx_t     idx;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        exception;
  } fu_result_t;

  // Architectural writeback at commit
  typedef struct packed {
    logic        valid;
    logic        wen;
    logic [4:0]  rd;
    logic [31:0] data;
  } commit_t;

  // Payload part of a buffer entry
  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] pc;
    logic [31:0] data;
  } cb_payload_t;

endpackage

// File: src/dispatch_steer.sv
`timescale 1ns/1ps

module dispatch_steer (
  input  logic                          dispatch_valid,
  input  ooo_commit_pkg::dispatch_req_t dispatch,
  input  logic                          dispatch_ready,
  input  ooo_commit_pkg::cb_idx_t       tail_idx,
  output logic                          alloc_ena,
  output logic [4:0]                    alloc_rd,
  output logic [31:0]                   alloc_pc,
  output ooo_commit_pkg::fu_issue_t     arith_issue,
  output ooo_commit_pkg::fu_issue_t     mul_issue
);

  logic accept;
  logic is_mul;

  // NOPs are dropped here and never take an entry
  assign accept = dispatch_valid & dispatch_ready &
                  (dispatch.op != ooo_commit_pkg::OP_NOP);

  assign is_mul = (dispatch.op == ooo_commit_pkg::OP_MUL);

  // Allocation at the tail of the buffer
  assign alloc_ena = accept;
  assign alloc_rd  = dispatch.rd;
  assign alloc_pc  = dispatch.pc;

  always_comb begin
    // Both ports see the same tagged payload
    arith_issue.op  = dispatch.op;
    arith_issue.idx = tail_idx;
    arith_issue.a   = dispatch.a;
    arith_issue.b   = dispatch.b;
    mul_issue.op    = dispatch.op;
    mul_issue.idx   = tail_idx;
    mul_issue.a     = dispatch.a;
    mul_issue.b     = dispatch.b;
    // Only one of them is strobed
    // Illegal opcodes go to arith, which raises the exception
    arith_issue.valid = accept & ~is_mul;
    mul_issue.valid   = accept & is_mul;
  end

endmodule

// File: src/arith_unit.sv
`timescale 1ns/1ps

module arith_unit (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       flush,
  input  ooo_commit_pkg::fu_issue_t  issue,
  input  logic [4:0]                 issue_rd,
  output ooo_commit_pkg::fu_result_t result
);

  logic                    valid_q;
  ooo_commit_pkg::cb_idx_t idx_q;
  logic [4:0]              rd_q;
  logic [31:0]             data_q;
  logic                    exc_q;

  logic [31:0] alu_out;
  logic        alu_exc;

  // Opcode decode and ALU
  always_comb begin
    alu_out = '0;
    alu_exc = 1'b0;
    case (issue.op)
      ooo_commit_pkg::OP_ADD: alu_out = issue.a + issue.b;
      ooo_commit_pkg::OP_SUB: alu_out = issue.a - issue.b;
      ooo_commit_pkg::OP_XOR: alu_out = issue.a ^ issue.b;
      // OP_ILLEGAL and unknown encodings trap with zero data
      default: alu_exc = 1'b1;
    endcase
  end

  // Result strobe, killed by flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue.valid;
    end
  end

  // Result payload
  always_ff @(posedge CLK) begin
    if (issue.valid) begin
      idx_q  <= issue.idx;
      rd_q   <= issue_rd;
      data_q <= alu_out;
      exc_q  <= alu_exc;
    end
  end

  assign result = '{valid: valid_q, idx: idx_q, rd: rd_q, data: data_q, exception: exc_q};

endmodule

// File: src/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       flush,
  input  ooo_commit_pkg::fu_issue_t  issue,
  input  logic [4:0]                 issue_rd,
  output ooo_commit_pkg::fu_result_t result
);

  // Stage valids, index 0 is the first stage
  logic [2:0]              valid_q;
  ooo_commit_pkg::cb_idx_t idx_q [3];
  logic [4:0]              rd_q  [3];

  // Partial products of the 16-bit halves
  logic [31:0] lh_full;
  logic [31:0] hl_full;
  logic [31:0] s1_ll;
  logic [15:0] s1_lh;
  logic [15:0] s1_hl;
  logic [31:0] s2_ll;
  logic [15:0] s2_cross;
  logic [31:0] s3_prod;

  // Only the low 16 bits of the cross terms reach the low word
  assign lh_full = issue.a[15:0] * issue.b[31:16];
  assign hl_full = issue.a[31:16] * issue.b[15:0];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else if (flush) begin
      // Every multiply in flight is younger than the trap
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[1:0], issue.valid & (issue.op == ooo_commit_pkg::OP_MUL)};
    end
  end

  always_ff @(posedge CLK) begin
    // Stage 1 forms the partial products
    idx_q[0] <= issue.idx;
    rd_q[0]  <= issue_rd;
    s1_ll    <= issue.a[15:0] * issue.b[15:0];
    s1_lh    <= lh_full[15:0];
    s1_hl    <= hl_full[15:0];
    // Stage 2 sums the cross terms
    idx_q[1] <= idx_q[0];
    rd_q[1]  <= rd_q[0];
    s2_ll    <= s1_ll;
    s2_cross <= s1_lh + s1_hl;
    // Stage 3 shifts the cross sum in and adds
    idx_q[2] <= idx_q[1];
    rd_q[2]  <= rd_q[1];
    s3_prod  <= s2_ll + {s2_cross, 16'h0000};
  end

  // Multiply never traps
  assign result = '{valid: valid_q[2], idx: idx_q[2], rd: rd_q[2], data: s3_prod,
                    exception: 1'b0};

endmodule

// File: src/completion_buffer.sv
`timescale 1ns/1ps

module completion_buffer (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       alloc_ena,
  input  logic [4:0]                 alloc_rd,
  input  logic [31:0]                alloc_pc,
  input  ooo_commit_pkg::fu_result_t arith_res,
  input  ooo_commit_pkg::fu_result_t mul_res,
  output ooo_commit_pkg::cb_idx_t    tail_idx,
  output logic                       dispatch_ready,
  output logic                       flush,
  output ooo_commit_pkg::commit_t    commit,
  output logic                       exception,
  output logic [31:0]                epc
);

  // Pointers carry one extra wrap bit above the index
  ooo_commit_pkg::cb_ptr_t head;
  ooo_commit_pkg::cb_ptr_t tail;
  ooo_commit_pkg::cb_idx_t head_sel;
  ooo_commit_pkg::cb_idx_t tail_sel;

  // Per-entry control flags
  logic [ooo_commit_pkg::CB_DEPTH-1:0] busy;
  logic [ooo_commit_pkg::CB_DEPTH-1:0] done;
  logic [ooo_commit_pkg::CB_DEPTH-1:0] excp;

  // Per-entry rd, pc and result data
  ooo_commit_pkg::cb_payload_t payload [ooo_commit_pkg::CB_DEPTH];

  logic full;
  logic move_head;
  logic move_tail;

  assign head_sel = head[ooo_commit_pkg::CB_IDX_W-1:0];
  assign tail_sel = tail[ooo_commit_pkg::CB_IDX_W-1:0];
  assign tail_idx = tail_sel;

  // Same index but different wrap bit means every entry is taken
  assign full = (head_sel == tail_sel) &&
                (head[ooo_commit_pkg::CB_IDX_W] != tail[ooo_commit_pkg::CB_IDX_W]);

  // Finished head entry that trapped flushes everything
  assign flush     = busy[head_sel] & done[head_sel] & excp[head_sel];
  assign exception = flush;
  assign epc       = payload[head_sel].pc;

  // No new work while full or while the flush is in progress
  assign dispatch_ready = ~full & ~flush;

  // Head commits as soon as its result is in and clean
  always_comb begin
    commit.valid = busy[head_sel] & done[head_sel] & ~excp[head_sel];
    commit.rd    = payload[head_sel].rd;
    commit.data  = payload[head_sel].data;
    // x0 is never written back
    commit.wen   = commit.valid & (payload[head_sel].rd != 5'd0);
  end

  assign move_head = commit.valid;
  assign move_tail = alloc_ena & dispatch_ready;

  // Pointers and control flags
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head <= '0;
      tail <= '0;
      busy <= '0;
      done <= '0;
      excp <= '0;
    end else if (flush) begin
      // Drop every outstanding entry, older ones already retired
      head <= '0;
      tail <= '0;
      busy <= '0;
      done <= '0;
      excp <= '0;
    end else begin
      if (move_tail) begin
        busy[tail_sel] <= 1'b1;
        done[tail_sel] <= 1'b0;
        excp[tail_sel] <= 1'b0;
        tail           <= tail + 1'b1;
      end
      // Results land out of order at their own index
      if (arith_res.valid) begin
        done[arith_res.idx] <= 1'b1;
        excp[arith_res.idx] <= arith_res.exception;
      end
      if (mul_res.valid) begin
        done[mul_res.idx] <= 1'b1;
        excp[mul_res.idx] <= mul_res.exception;
      end
      // Retired entry is freed for reuse
      if (move_head) begin
        busy[head_sel] <= 1'b0;
        done[head_sel] <= 1'b0;
        excp[head_sel] <= 1'b0;
        head           <= head + 1'b1;
      end
    end
  end

  // Entry payload, qualified by the flags above
  always_ff @(posedge CLK) begin
    if (move_tail) begin
      payload[tail_sel].rd <= alloc_rd;
      payload[tail_sel].pc <= alloc_pc;
    end
    // rd comes back with the result and matches the allocated one
    if (arith_res.valid) begin
      payload[arith_res.idx].rd   <= arith_res.rd;
      payload[arith_res.idx].data <= arith_res.data;
    end
    if (mul_res.valid) begin
      payload[mul_res.idx].rd   <= mul_res.rd;
      payload[mul_res.idx].data <= mul_res.data;
    end
  end

endmodule

// File: src/ooo_commit_top.sv
`timescale 1ns/1ps

module ooo_commit_top (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          dispatch_valid,
  input  ooo_commit_pkg::dispatch_req_t dispatch,
  output logic                          dispatch_ready,
  output ooo_commit_pkg::commit_t       commit,
  output logic                          exception,
  output logic [31:0]                   epc
);

  // Steer to buffer
  logic                    alloc_ena;
  logic [4:0]              alloc_rd;
  logic [31:0]             alloc_pc;
  ooo_commit_pkg::cb_idx_t tail_idx;

  // Steer to units, units to buffer
  ooo_commit_pkg::fu_issue_t  arith_issue;
  ooo_commit_pkg::fu_issue_t  mul_issue;
  ooo_commit_pkg::fu_result_t arith_res;
  ooo_commit_pkg::fu_result_t mul_res;
  logic                       flush;

  dispatch_steer u_steer (
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .tail_idx       (tail_idx),
    .alloc_ena      (alloc_ena),
    .alloc_rd       (alloc_rd),
    .alloc_pc       (alloc_pc),
    .arith_issue    (arith_issue),
    .mul_issue      (mul_issue)
  );

  // rd rides along with the issue straight from the request
  arith_unit u_arith (
    .CLK      (CLK),
    .nRST     (nRST),
    .flush    (flush),
    .issue    (arith_issue),
    .issue_rd (dispatch.rd),
    .result   (arith_res)
  );

  mul_unit u_mul (
    .CLK      (CLK),
    .nRST     (nRST),
    .flush    (flush),
    .issue    (mul_issue),
    .issue_rd (dispatch.rd),
    .result   (mul_res)
  );

  completion_buffer u_cb (
    .CLK            (CLK),
    .nRST           (nRST),
    .alloc_ena      (alloc_ena),
    .alloc_rd       (alloc_rd),
    .alloc_pc       (alloc_pc),
    .arith_res      (arith_res),
    .mul_res        (mul_res),
    .tail_idx       (tail_idx),
    .dispatch_ready (dispatch_ready),
    .flush          (flush),
    .commit         (commit),
    .exception      (exception),
    .epc            (epc)
  );

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
  output logic CLK,
  output logic nRST
);

  // 10 ns period, first rising edge at 5 ns
  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  // Reset held over five rising edges, released just after the fifth
  initial begin
    nRST = 1'b0;
    repeat (5) @(posedge CLK);
    #1 nRST = 1'b1;
  end

endmodule

// File: dv/ooo_commit_properties.sv
`timescale 1ns/1ps

module ooo_commit_properties (
  input logic                    CLK,
  input logic                    nRST,
  input ooo_commit_pkg::cb_ptr_t head,
  input ooo_commit_pkg::cb_ptr_t tail,
  input logic                    flush,
  input logic                    commit_valid,
  input logic                    exception,
  input logic                    dispatch_ready
);

  int         fail_count;
  logic [3:0] occupancy;

  // Wrap bit makes the difference the live entry count
  assign occupancy = tail - head;

  a_occupancy: assert property (@(posedge CLK) disable iff (!nRST)
    occupancy <= 4'(ooo_commit_pkg::CB_DEPTH))
    else begin
      $error("Head and tail pointers more than the buffer depth apart");
      fail_count++;
    end

  a_commit_or_trap: assert property (@(posedge CLK) disable iff (!nRST)
    !(commit_valid && exception))
    else begin
      $error("Commit and exception raised together");
      fail_count++;
    end

  // Flush empties the buffer, so it cannot repeat
  a_flush_single: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !flush)
    else begin
      $error("Flush held for more than one cycle");
      fail_count++;
    end

  // Full taken from the live entry count, not from the buffer's own flag
  a_full_stalls: assert property (@(posedge CLK) disable iff (!nRST)
    (occupancy == 4'(ooo_commit_pkg::CB_DEPTH)) |-> !dispatch_ready)
    else begin
      $error("Dispatch ready while the buffer is full");
      fail_count++;
    end

endmodule

bind completion_buffer ooo_commit_properties u_props (
  .CLK            (CLK),
  .nRST           (nRST),
  .head           (head),
  .tail           (tail),
  .flush          (flush),
  .commit_valid   (commit.valid),
  .exception      (exception),
  .dispatch_ready (dispatch_ready)
);

// File: dv/commit_checker.sv
`timescale 1ns/1ps

module commit_checker (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          dispatch_valid,
  input  ooo_commit_pkg::dispatch_req_t dispatch,
  input  logic                          dispatch_ready,
  input  ooo_commit_pkg::commit_t       commit,
  input  logic                          exception,
  input  logic [31:0]                   epc,
  output int                            err_count,
  output int                            check_count,
  output int                            pending
);

  // Expected outcome of one accepted instruction
  typedef struct packed {
    logic        trap;
    logic [4:0]  rd;
    logic [31:0] pc;
    logic [31:0] data;
  } expect_t;

  // Program-order model of everything not yet retired
  expect_t model_q [$];

  function automatic logic [31:0] predict_data(input ooo_commit_pkg::opcode_t op,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
    case (op)
      ooo_commit_pkg::OP_ADD: return a + b;
      ooo_commit_pkg::OP_SUB: return a - b;
      ooo_commit_pkg::OP_XOR: return a ^ b;
      // Low word of the product only
      ooo_commit_pkg::OP_MUL: return a * b;
      default:                return 32'd0;
    endcase
  endfunction

  task automatic check_value(input string sig, input logic [31:0] exp_val,
                             input logic [31:0] act_val, input logic [31:0] pc);
    check_count++;
    if (exp_val !== act_val) begin
      err_count++;
      $display("** Error: %s expected 0x%08h actual 0x%08h (pc 0x%08h)",
               sig, exp_val, act_val, pc);
    end
  endtask

  task automatic report_failure(input string what);
    err_count++;
    $display("At %0t: %s", $time, what);
  endtask

  // Sampled mid-cycle, describing what the next rising edge does
  always @(negedge CLK) begin : sample
    expect_t oldest;
    if (!nRST) begin
      // Idle outputs while in reset
      check_value("commit.valid", 32'd0, 32'(commit.valid), 32'd0);
      check_value("exception", 32'd0, 32'(exception), 32'd0);
      check_value("dispatch_ready", 32'd1, 32'(dispatch_ready), 32'd0);
      model_q.delete();
    end else begin
      // Ready follows the live entry count and drops while flushing
      check_value("dispatch_ready",
                  32'((model_q.size() < ooo_commit_pkg::CB_DEPTH) && !exception),
                  32'(dispatch_ready), 32'd0);
      if (exception) begin
        if (model_q.size() == 0) begin
          report_failure("Exception raised with no instruction outstanding");
        end else begin
          oldest = model_q.pop_front();
          if (!oldest.trap) begin
            report_failure($sformatf("Exception raised by pc 0x%08h, which should not trap",
                                     oldest.pc));
          end
          check_value("epc", oldest.pc, epc, oldest.pc);
          // Younger instructions die with the flush
          model_q.delete();
        end
      end else if (commit.valid) begin
        if (model_q.size() == 0) begin
          report_failure("Commit seen with no instruction outstanding");
        end else begin
          oldest = model_q.pop_front();
          if (oldest.trap) begin
            report_failure($sformatf("Instruction at pc 0x%08h committed instead of trapping",
                                     oldest.pc));
          end else begin
            check_value("commit.rd", 32'(oldest.rd), 32'(commit.rd), oldest.pc);
            check_value("commit.wen", 32'(oldest.rd != 5'd0), 32'(commit.wen), oldest.pc);
            check_value("commit.data", oldest.data, commit.data, oldest.pc);
          end
        end
      end
      // NOPs never take an entry
      if (dispatch_valid && dispatch_ready && dispatch.op != ooo_commit_pkg::OP_NOP) begin
        model_q.push_back('{trap: dispatch.op == ooo_commit_pkg::OP_ILLEGAL,
                            rd:   dispatch.rd,
                            pc:   dispatch.pc,
                            data: predict_data(dispatch.op, dispatch.a, dispatch.b)});
      end
    end
    pending = model_q.size();
  end

endmodule

// File: dv/ooo_commit_tb.sv
`timescale 1ns/1ps

module ooo_commit_tb;

  typedef enum int {
    MIX_ALU,
    MIX_MUL_FIRST,
    MIX_MUL_ONLY,
    MIX_BURST,
    MIX_NOP,
    MIX_RANDOM
  } mix_t;

  typedef struct {
    string name;
    int    count;
    mix_t  mix;
    int    exc_pos;
  } test_row_t;

  localparam int WAIT_CYCLES = 100;

  // Name, instruction count, opcode mix, index forced to OP_ILLEGAL (-1 for none)
  test_row_t test_table [8] = '{
    '{"alu_order",     12, MIX_ALU,       -1},
    '{"mul_then_add",   8, MIX_MUL_FIRST, -1},
    '{"mul_b2b",        6, MIX_MUL_ONLY,  -1},
    '{"burst_fill",    24, MIX_BURST,     -1},
    '{"nop_skip",      10, MIX_NOP,       -1},
    '{"illegal_flush", 10, MIX_BURST,      4},
    '{"after_flush",    6, MIX_ALU,       -1},
    '{"random_mix",    80, MIX_RANDOM,    -1}
  };

  logic                          CLK;
  logic                          nRST;
  logic                          dispatch_valid;
  ooo_commit_pkg::dispatch_req_t dispatch;
  logic                          dispatch_ready;
  ooo_commit_pkg::commit_t       commit;
  logic                          exception;
  logic [31:0]                   epc;
  int                            err_count;
  int                            check_count;
  int                            pending;
  logic [31:0]                   lfsr_state;
  logic [31:0]                   next_pc;
  bit                            timed_out;

  clk_gen u_clk (.CLK(CLK), .nRST(nRST));

  ooo_commit_top uut (
    .CLK            (CLK),
    .nRST           (nRST),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .commit         (commit),
    .exception      (exception),
    .epc            (epc)
  );

  commit_checker u_chk (
    .CLK            (CLK),
    .nRST           (nRST),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .commit         (commit),
    .exception      (exception),
    .epc            (epc),
    .err_count      (err_count),
    .check_count    (check_count),
    .pending        (pending)
  );

  // Galois LFSR, one step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        out_bit;
    val = '0;
    for (int i = 0; i < n; i++) begin
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) lfsr_state = lfsr_state ^ 32'h8020_0003;
      val = {val[30:0], out_bit};
    end
    return val;
  endfunction

  function automatic ooo_commit_pkg::opcode_t alu_op(input int i);
    case (i % 3)
      0:       return ooo_commit_pkg::OP_ADD;
      1:       return ooo_commit_pkg::OP_SUB;
      default: return ooo_commit_pkg::OP_XOR;
    endcase
  endfunction

  function automatic ooo_commit_pkg::dispatch_req_t make_instr(input mix_t mix, input int i,
                                                               input int exc_pos);
    ooo_commit_pkg::dispatch_req_t req;
    logic [31:0]                   bits;
    req.a   = take_bits(32);
    req.b   = take_bits(32);
    bits    = take_bits(5);
    req.rd  = bits[4:0];
    req.pc  = next_pc;
    next_pc = next_pc + 32'd4;
    case (mix)
      // Small rd range so x0 shows up often
      MIX_ALU: begin
        req.op = alu_op(i);
        req.rd = 5'(i % 4);
      end
      MIX_MUL_FIRST: req.op = (i == 0) ? ooo_commit_pkg::OP_MUL : ooo_commit_pkg::OP_ADD;
      MIX_MUL_ONLY:  req.op = ooo_commit_pkg::OP_MUL;
      MIX_BURST:     req.op = (i % 3 == 0) ? ooo_commit_pkg::OP_MUL : alu_op(i);
      MIX_NOP:       req.op = (i % 2 == 1) ? ooo_commit_pkg::OP_NOP : alu_op(i);
      default: begin
        // 1 in 16 illegal, 1 in 16 NOP, rest split between mul and alu
        bits = take_bits(4);
        if (bits[3:0] == 4'd0) req.op = ooo_commit_pkg::OP_ILLEGAL;
        else if (bits[3:0] == 4'd1) req.op = ooo_commit_pkg::OP_NOP;
        else if (bits[3:0] < 4'd7) req.op = ooo_commit_pkg::OP_MUL;
        else req.op = alu_op(int'(bits[3:0]));
      end
    endcase
    if (i == exc_pos) req.op = ooo_commit_pkg::OP_ILLEGAL;
    return req;
  endfunction

  // Holds the request until a rising edge with ready high
  task automatic send_instr(input ooo_commit_pkg::dispatch_req_t req, input string test_name);
    int waited;
    waited         = 0;
    dispatch_valid = 1'b1;
    dispatch       = req;
    @(negedge CLK);
    while (!dispatch_ready && waited < WAIT_CYCLES) begin
      @(negedge CLK);
      waited++;
    end
    if (!dispatch_ready) begin
      $display("Timeout: dispatch_ready stayed low in test %s", test_name);
      timed_out = 1'b1;
    end else begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic wait_drain(input string test_name);
    int waited;
    waited         = 0;
    dispatch_valid = 1'b0;
    dispatch       = '0;
    @(posedge CLK);
    while (pending != 0 && waited < WAIT_CYCLES) begin
      @(posedge CLK);
      waited++;
    end
    if (pending != 0) begin
      $display("Timeout: %0d instructions never retired in test %s", pending, test_name);
      timed_out = 1'b1;
    end else begin
      // Idle gap so a stray late commit is caught in this test
      repeat (2) @(posedge CLK);
      #1;
    end
  endtask

  initial begin
    int                            waited;
    int                            errs_before;
    int                            checks_before;
    int                            total_errors;
    ooo_commit_pkg::dispatch_req_t req;
    dispatch_valid = 1'b0;
    dispatch       = '0;
    lfsr_state     = 32'd58;
    next_pc        = 32'h0000_1000;
    timed_out      = 1'b0;
    waited         = 0;
    while (nRST !== 1'b1 && waited < 20) begin
      @(posedge CLK);
      waited++;
    end
    if (nRST !== 1'b1) begin
      $display("Timeout: reset was never released");
      timed_out = 1'b1;
    end else begin
      @(posedge CLK);
      #1;
    end
    foreach (test_table[t]) begin
      if (!timed_out) begin
        errs_before   = err_count;
        checks_before = check_count;
        for (int i = 0; i < test_table[t].count && !timed_out; i++) begin
          req = make_instr(test_table[t].mix, i, test_table[t].exc_pos);
          send_instr(req, test_table[t].name);
        end
        if (!timed_out) begin
          wait_drain(test_table[t].name);
        end
        if (!timed_out) begin
          $display("Test %-14s %0d checks, %0d errors", test_table[t].name,
                   check_count - checks_before, err_count - errs_before);
        end
      end
    end
    total_errors = err_count + uut.u_cb.u_props.fail_count;
    $display("Summary: %0d tests, %0d checks, %0d errors", $size(test_table),
             check_count, total_errors);
    if (total_errors == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: ooo_commit.f
src/ooo_commit_pkg.sv
src/dispatch_steer.sv
src/arith_unit.sv
src/mul_unit.sv
src/completion_buffer.sv
src/ooo_commit_top.sv
dv/clk_gen.sv
dv/ooo_commit_properties.sv
dv/commit_checker.sv
dv/ooo_commit_tb.sv

// File: Makefile
TOP := ooo_commit_tb
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f ooo_commit.f --top-module $(TOP) -Mdir $(OBJ) -o sim

run: build
	./$(OBJ)/sim | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f ooo_commit.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) sim.log
